// ==== verilog/cpu_macros.svh ====
// cpu macros
// field positions, widths and fixed register numbers shared by the
// decode stage and its testbench
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// instruction fields
`define OPCODE_MSB 31
`define OPCODE_LSB 27
`define RD_MSB 26
`define RD_LSB 22
`define RS1_MSB 21
`define RS1_LSB 17
`define RS2_MSB 16
`define RS2_LSB 12

// datapath widths
`define DATA_W 32
`define REG_NUM_W 5
`define FLAG_W 2

// registers that general writes may not touch
`define REG_ZERO 5'd0
`define REG_LR 5'd30
`define REG_FL 5'd31

// instruction memory starts here, upper half of a jump target
`define IMEM_PREFIX 16'h1000

// illegal opcode marker, all ones
`define ERR_FILL 32'hFFFF_FFFF

`endif

// ==== verilog/cpu_pkg.sv ====
// cpu package
// opcode encoding and the bundles passed between pipeline stages
`include "cpu_macros.svh"

package cpu_pkg;

	// codes 23 to 30 are unassigned
	typedef enum logic [4:0] {
		OP_ADD  = 5'd0,  OP_ADDI = 5'd1,  OP_SUB  = 5'd2,  OP_SUBI = 5'd3,
		OP_AND  = 5'd4,  OP_OR   = 5'd5,  OP_XOR  = 5'd6,  OP_NEG  = 5'd7,
		OP_SLL  = 5'd8,  OP_SLR  = 5'd9,  OP_SAR  = 5'd10,
		OP_LD   = 5'd11, OP_LDI  = 5'd12, OP_ST   = 5'd13, OP_STI  = 5'd14,
		OP_NOP  = 5'd15,
		OP_BEQ  = 5'd16, OP_BNE  = 5'd17, OP_BON  = 5'd18, OP_BNN  = 5'd19,
		OP_J    = 5'd20, OP_JR   = 5'd21, OP_JAL  = 5'd22,
		OP_RIN  = 5'd31
	} opcode_e;

	// controls for execute, memory and writeback
	typedef struct packed {
		logic [1:0] alu_src;            // 0 imm, 1 reg 2
		logic [4:0] alu_op;
		logic branch;
		logic jump;
		logic mem_en;
		logic mem_wrt;
		logic [1:0] result_sel;         // 0 alu, 1 mem, 2 pc
		logic reg_wrt_en;
		logic [`REG_NUM_W-1:0] reg_wrt_sel;
		logic lr_read;
		logic lr_write;
		logic fl_read;
		logic fl_write;
	} ctrl_t;

	typedef struct packed {
		logic en;
		logic [`REG_NUM_W-1:0] sel;
		logic [`DATA_W-1:0] data;
	} reg_wr_t;

	typedef struct packed {
		logic lr_write;
		logic [`DATA_W-1:0] lr_data;
		logic fl_write;
		logic [`FLAG_W-1:0] fl_data;
	} spec_wr_t;

	typedef struct packed {
		logic [`DATA_W-1:0] lr;
		logic [`FLAG_W-1:0] fl;
	} spec_val_t;

endpackage

// ==== verilog/instr_decoder.sv ====
// instruction decoder
// turns the opcode into the control bundle and builds the immediate
// in the format of each instruction class, flush gives a bubble
`timescale 1ns/1ns
`include "cpu_macros.svh"

module instr_decoder (
	input  logic [`DATA_W-1:0] instr,
	input  logic               flush,
	output cpu_pkg::ctrl_t     ctrl,
	output logic [`DATA_W-1:0] imm
);

	localparam cpu_pkg::ctrl_t NOP_CTRL = '{
		alu_src: 2'd1,
		alu_op:  cpu_pkg::OP_NOP,
		default: '0
	};

	cpu_pkg::opcode_e opcode;
	logic [`REG_NUM_W-1:0] rd;
	logic rs1_lr, rs1_fl, rs2_lr, rs2_fl;
	logic [`DATA_W-1:0] imm_sext, imm_zext, imm_jump;
	cpu_pkg::ctrl_t dec;
	logic [`DATA_W-1:0] dec_imm;

	assign opcode = cpu_pkg::opcode_e'(instr[`OPCODE_MSB:`OPCODE_LSB]);
	assign rd = instr[`RD_MSB:`RD_LSB];

	// source fields that name the special registers
	assign rs1_lr = (instr[`RS1_MSB:`RS1_LSB] == `REG_LR);
	assign rs1_fl = (instr[`RS1_MSB:`RS1_LSB] == `REG_FL);
	assign rs2_lr = (instr[`RS2_MSB:`RS2_LSB] == `REG_LR);
	assign rs2_fl = (instr[`RS2_MSB:`RS2_LSB] == `REG_FL);

	// immediate formats
	assign imm_sext = {{20{instr[11]}}, instr[11:0]};
	assign imm_zext = {16'h0000, instr[15:0]};
	assign imm_jump = {`IMEM_PREFIX, instr[13:0], 2'b00};    // word aligned

	always_comb begin
		dec = NOP_CTRL;
		dec.alu_op = opcode;
		dec_imm = '0;
		case (opcode)
			cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND, cpu_pkg::OP_OR,
			cpu_pkg::OP_XOR, cpu_pkg::OP_SLL, cpu_pkg::OP_SLR, cpu_pkg::OP_SAR: begin
				dec.reg_wrt_en = 1'b1;
				dec.reg_wrt_sel = rd;
				dec.lr_read = rs1_lr | rs2_lr;
				dec.fl_read = rs1_fl | rs2_fl;
				dec.fl_write = 1'b1;
			end
			cpu_pkg::OP_ADDI, cpu_pkg::OP_SUBI: begin
				dec.alu_src = 2'd0;
				dec_imm = imm_sext;
				dec.reg_wrt_en = 1'b1;
				dec.reg_wrt_sel = rd;
				dec.lr_read = rs1_lr;
				dec.fl_read = rs1_fl;
				dec.fl_write = 1'b1;
			end
			cpu_pkg::OP_NEG, cpu_pkg::OP_LD: begin
				dec.reg_wrt_en = 1'b1;
				dec.reg_wrt_sel = rd;
				dec.lr_read = rs1_lr;
				dec.fl_read = rs1_fl;
				dec.fl_write = 1'b1;
				// LD takes its result from memory
				dec.mem_en = (opcode == cpu_pkg::OP_LD);
				dec.result_sel = (opcode == cpu_pkg::OP_LD) ? 2'd1 : 2'd0;
			end
			cpu_pkg::OP_LDI: begin
				dec.alu_src = 2'd0;
				dec_imm = imm_zext;
				dec.mem_en = 1'b1;
				dec.result_sel = 2'd1;
				dec.reg_wrt_en = 1'b1;
				dec.reg_wrt_sel = rd;
				dec.fl_write = 1'b1;
			end
			cpu_pkg::OP_ST: begin
				dec.mem_en = 1'b1;
				dec.mem_wrt = 1'b1;
				dec.lr_read = rs1_lr;
				dec.fl_read = rs1_fl;
			end
			cpu_pkg::OP_STI: begin
				dec.alu_src = 2'd0;
				dec_imm = imm_zext;
				dec.mem_en = 1'b1;
				dec.mem_wrt = 1'b1;
			end
			cpu_pkg::OP_NOP, cpu_pkg::OP_RIN: begin
				// defaults only
			end
			cpu_pkg::OP_BEQ, cpu_pkg::OP_BNE, cpu_pkg::OP_BON, cpu_pkg::OP_BNN: begin
				dec.branch = 1'b1;
				dec.result_sel = 2'd2;
				dec.lr_read = rs1_lr;
				dec.fl_read = 1'b1;     // conditions live in FL
			end
			cpu_pkg::OP_J, cpu_pkg::OP_JAL: begin
				dec.alu_src = 2'd0;
				dec.jump = 1'b1;
				dec_imm = imm_jump;
				dec.result_sel = 2'd2;
				dec.lr_write = (opcode == cpu_pkg::OP_JAL);
			end
			cpu_pkg::OP_JR: begin
				dec.jump = 1'b1;
				dec.result_sel = 2'd2;
				dec.lr_read = rs1_lr;
				dec.fl_read = rs1_fl;
			end
			default: begin
				// illegal opcode, flag it with all ones
				dec = '1;
				dec_imm = `ERR_FILL;
			end
		endcase
	end

	assign ctrl = flush ? NOP_CTRL : dec;
	assign imm = flush ? '0 : dec_imm;

endmodule

// ==== verilog/reg_file_bypass.sv ====
// general register file
// 32 x 32 bits, two combinational read ports and one write port;
// a read of the register being written sees the new data at once.
// registers 0, 30 and 31 are never written and read as zero
`timescale 1ns/1ns
`include "cpu_macros.svh"

module reg_file_bypass (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [`REG_NUM_W-1:0] rs1_sel,
	input  logic [`REG_NUM_W-1:0] rs2_sel,
	input  cpu_pkg::reg_wr_t      wb,
	output logic [`DATA_W-1:0]    reg_1_data,
	output logic [`DATA_W-1:0]    reg_2_data
);

	logic [`DATA_W-1:0] regs [2**`REG_NUM_W];
	logic wr_ok;

	// protected registers drop the write
	assign wr_ok = wb.en &&
		(wb.sel != `REG_ZERO) && (wb.sel != `REG_LR) && (wb.sel != `REG_FL);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 2**`REG_NUM_W; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_ok) begin
			regs[wb.sel] <= wb.data;
		end
	end

	// protected entries stay at their reset value, so they read zero
	assign reg_1_data = (wr_ok && (wb.sel == rs1_sel)) ? wb.data : regs[rs1_sel];
	assign reg_2_data = (wr_ok && (wb.sel == rs2_sel)) ? wb.data : regs[rs2_sel];

endmodule

// ==== verilog/special_regs.sv ====
// special registers
// link register and flags, loaded from later stages or restored
// in one step when an interrupt returns
`timescale 1ns/1ns
`include "cpu_macros.svh"

module special_regs (
	input  logic                clk,
	input  logic                rst_n,
	input  cpu_pkg::spec_wr_t   spec_wr,
	input  logic                restore,
	input  cpu_pkg::spec_val_t  saved,
	output cpu_pkg::spec_val_t  spec
);

	cpu_pkg::spec_val_t spec_next;

	// restore beats the write strobes, which beat hold
	always_comb begin
		spec_next = spec;
		if (restore) begin
			spec_next = saved;
		end else begin
			if (spec_wr.lr_write) begin
				spec_next.lr = spec_wr.lr_data;
			end
			if (spec_wr.fl_write) begin
				spec_next.fl = spec_wr.fl_data;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			spec <= '0;
		end else begin
			spec <= spec_next;
		end
	end

endmodule

// ==== verilog/decode_stage.sv ====
// decode stage
// splits the instruction, builds the control bundle and immediate,
// reads both source operands and keeps LR and FL
`timescale 1ns/1ns
`include "cpu_macros.svh"

module decode_stage (
	input  logic               clk,
	input  logic               rst_n,
	input  logic [`DATA_W-1:0] instr,
	input  logic               flush,
	input  cpu_pkg::reg_wr_t   wb,
	input  cpu_pkg::spec_wr_t  spec_wr,
	input  logic               restore,
	input  cpu_pkg::spec_val_t saved,
	output cpu_pkg::ctrl_t     ctrl,
	output logic [`DATA_W-1:0] imm,
	output logic [`DATA_W-1:0] reg_1_data,
	output logic [`DATA_W-1:0] reg_2_data,
	output cpu_pkg::spec_val_t spec
);

	logic [`REG_NUM_W-1:0] rs1_sel;
	logic [`REG_NUM_W-1:0] rs2_sel;

	assign rs1_sel = instr[`RS1_MSB:`RS1_LSB];
	assign rs2_sel = instr[`RS2_MSB:`RS2_LSB];

	instr_decoder i_decoder (
		.instr (instr),
		.flush (flush),
		.ctrl  (ctrl),
		.imm   (imm)
	);

	// operands read straight from the source fields
	reg_file_bypass i_reg_file (
		.clk        (clk),
		.rst_n      (rst_n),
		.rs1_sel    (rs1_sel),
		.rs2_sel    (rs2_sel),
		.wb         (wb),
		.reg_1_data (reg_1_data),
		.reg_2_data (reg_2_data)
	);

	special_regs i_special_regs (
		.clk     (clk),
		.rst_n   (rst_n),
		.spec_wr (spec_wr),
		.restore (restore),
		.saved   (saved),
		.spec    (spec)
	);

endmodule

// ==== tb/decode_checker.sv ====
// decode checker
// watches the decode stage ports, predicts every output from a
// reference decoder and a register model, and counts the compares
`timescale 1ns/1ns
`include "cpu_macros.svh"

module decode_checker (
	input  logic               clk,
	input  logic               rst_n,
	input  logic [`DATA_W-1:0] instr,
	input  logic               flush,
	input  cpu_pkg::reg_wr_t   wb,
	input  cpu_pkg::spec_wr_t  spec_wr,
	input  logic               restore,
	input  cpu_pkg::spec_val_t saved,
	input  cpu_pkg::ctrl_t     ctrl,
	input  logic [`DATA_W-1:0] imm,
	input  logic [`DATA_W-1:0] reg_1_data,
	input  logic [`DATA_W-1:0] reg_2_data,
	input  cpu_pkg::spec_val_t spec,
	output int                 pass_cnt,
	output int                 fail_cnt
);

	typedef struct packed {
		cpu_pkg::ctrl_t ctrl;
		logic [`DATA_W-1:0] imm;
	} expect_t;

	logic [`DATA_W-1:0] ref_regs [2**`REG_NUM_W];
	cpu_pkg::spec_val_t ref_spec;
	expect_t exp_dec;

	function automatic logic is_protected(input logic [`REG_NUM_W-1:0] sel);
		return (sel == `REG_ZERO) || (sel == `REG_LR) || (sel == `REG_FL);
	endfunction

	// expected controls and immediate, built class by class
	function automatic expect_t ref_decode(input logic [`DATA_W-1:0] ins, input logic bubble);
		expect_t e;
		cpu_pkg::opcode_e op;
		logic [`REG_NUM_W-1:0] rs1;
		logic [`REG_NUM_W-1:0] rs2;
		logic alu_rr, alu_imm, loads, stores, is_branch, jump_abs, writes_rd;
		op = cpu_pkg::opcode_e'(ins[`OPCODE_MSB:`OPCODE_LSB]);
		rs1 = ins[`RS1_MSB:`RS1_LSB];
		rs2 = ins[`RS2_MSB:`RS2_LSB];
		e = '0;
		e.ctrl.alu_src = 2'd1;
		e.ctrl.alu_op = bubble ? cpu_pkg::OP_NOP : op;
		if (bubble) begin
			return e;
		end
		if (ins[`OPCODE_MSB:`OPCODE_LSB] inside {[5'd23:5'd30]}) begin
			e.ctrl = '1;
			e.imm = `ERR_FILL;
			return e;
		end
		alu_rr = op inside {cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND, cpu_pkg::OP_OR,
			cpu_pkg::OP_XOR, cpu_pkg::OP_SLL, cpu_pkg::OP_SLR, cpu_pkg::OP_SAR};
		alu_imm = op inside {cpu_pkg::OP_ADDI, cpu_pkg::OP_SUBI};
		loads = op inside {cpu_pkg::OP_LD, cpu_pkg::OP_LDI};
		stores = op inside {cpu_pkg::OP_ST, cpu_pkg::OP_STI};
		is_branch = op inside {cpu_pkg::OP_BEQ, cpu_pkg::OP_BNE, cpu_pkg::OP_BON, cpu_pkg::OP_BNN};
		jump_abs = op inside {cpu_pkg::OP_J, cpu_pkg::OP_JAL};
		writes_rd = alu_rr | alu_imm | loads | (op == cpu_pkg::OP_NEG);
		e.ctrl.reg_wrt_en = writes_rd;
		e.ctrl.reg_wrt_sel = writes_rd ? ins[`RD_MSB:`RD_LSB] : '0;
		e.ctrl.fl_write = writes_rd;
		e.ctrl.mem_en = loads | stores;
		e.ctrl.mem_wrt = stores;
		e.ctrl.branch = is_branch;
		e.ctrl.jump = jump_abs | (op == cpu_pkg::OP_JR);
		e.ctrl.lr_write = (op == cpu_pkg::OP_JAL);
		if (loads) begin
			e.ctrl.result_sel = 2'd1;
		end else if (is_branch || e.ctrl.jump) begin
			e.ctrl.result_sel = 2'd2;
		end
		// register sources that may name LR or FL
		if (writes_rd && (op != cpu_pkg::OP_LDI) || is_branch ||
			op inside {cpu_pkg::OP_ST, cpu_pkg::OP_JR}) begin
			e.ctrl.lr_read = (rs1 == `REG_LR);
			e.ctrl.fl_read = (rs1 == `REG_FL);
		end
		if (alu_rr) begin
			e.ctrl.lr_read |= (rs2 == `REG_LR);
			e.ctrl.fl_read |= (rs2 == `REG_FL);
		end
		e.ctrl.fl_read |= is_branch;
		if (alu_imm) begin
			e.ctrl.alu_src = 2'd0;
			e.imm = $signed(ins[11:0]);
		end else if (op inside {cpu_pkg::OP_LDI, cpu_pkg::OP_STI}) begin
			e.ctrl.alu_src = 2'd0;
			e.imm = 32'(ins[15:0]);
		end else if (jump_abs) begin
			e.ctrl.alu_src = 2'd0;
			e.imm = (32'(`IMEM_PREFIX) << 16) | (32'(ins[13:0]) << 2);
		end
		return e;
	endfunction

	function automatic logic [`DATA_W-1:0] expect_read(input logic [`REG_NUM_W-1:0] sel);
		if (wb.en && !is_protected(wb.sel) && (wb.sel == sel)) begin
			return wb.data;
		end
		return is_protected(sel) ? '0 : ref_regs[sel];
	endfunction

	task automatic compare_value(input string name, input logic [63:0] exp_v,
		input logic [63:0] act_v);
		if (act_v === exp_v) begin
			pass_cnt++;
		end else begin
			$display("[FAIL] %0t ns %s expected %h actual %h", $time, name, exp_v, act_v);
			fail_cnt++;
		end
	endtask

	initial begin
		pass_cnt = 0;
		fail_cnt = 0;
	end

	// reference state follows the inputs seen at each edge
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 2**`REG_NUM_W; i++) begin
				ref_regs[i] <= '0;
			end
			ref_spec <= '0;
		end else begin
			if (wb.en && !is_protected(wb.sel)) begin
				ref_regs[wb.sel] <= wb.data;
			end
			if (restore) begin
				ref_spec <= saved;
			end else begin
				if (spec_wr.lr_write) begin
					ref_spec.lr <= spec_wr.lr_data;
				end
				if (spec_wr.fl_write) begin
					ref_spec.fl <= spec_wr.fl_data;
				end
			end
		end
	end

	// inputs and outputs settle by mid cycle
	always @(negedge clk) begin
		if (rst_n) begin
			exp_dec = ref_decode(instr, flush);
			compare_value("ctrl", exp_dec.ctrl, ctrl);
			compare_value("imm", exp_dec.imm, imm);
			compare_value("reg_1_data", expect_read(instr[`RS1_MSB:`RS1_LSB]), reg_1_data);
			compare_value("reg_2_data", expect_read(instr[`RS2_MSB:`RS2_LSB]), reg_2_data);
			compare_value("spec", ref_spec, spec);
		end
	end

endmodule

// ==== tb/tb_decode_stage.sv ====
// decode stage testbench
// directed opcode, register and special register tests followed by
// random traffic, all compared by the checker
`timescale 1ns/1ns
`include "cpu_macros.svh"

module tb_decode_stage;

	localparam int RESET_CYC = 3;
	localparam int T1_CYC = 48;     // 24 legal opcodes, two field sets
	localparam int T2_CYC = 40;     // 8 illegal, 32 flushed
	localparam int T3_CYC = 64;
	localparam int T4_CYC = 9;
	localparam int T5_CYC = 300;
	localparam int CYCLE_LIMIT = RESET_CYC + T1_CYC + T2_CYC + T3_CYC + T4_CYC + T5_CYC + 200;

	logic clk;
	logic rst_n;
	logic [`DATA_W-1:0] instr;
	logic flush;
	cpu_pkg::reg_wr_t wb;
	cpu_pkg::spec_wr_t spec_wr;
	logic restore;
	cpu_pkg::spec_val_t saved;
	cpu_pkg::ctrl_t ctrl;
	logic [`DATA_W-1:0] imm;
	logic [`DATA_W-1:0] reg_1_data;
	logic [`DATA_W-1:0] reg_2_data;
	cpu_pkg::spec_val_t spec;
	int seed = 74116;
	int cycle_cnt = 0;
	int pass_cnt;
	int fail_cnt;
	int fail_mark = 0;
	logic [31:0] rnd;
	logic [`REG_NUM_W-1:0] prot [3] = '{`REG_ZERO, `REG_LR, `REG_FL};

	decode_stage i_dut (
		.clk(clk), .rst_n(rst_n), .instr(instr), .flush(flush), .wb(wb),
		.spec_wr(spec_wr), .restore(restore), .saved(saved), .ctrl(ctrl), .imm(imm),
		.reg_1_data(reg_1_data), .reg_2_data(reg_2_data), .spec(spec)
	);

	decode_checker i_chk (
		.clk(clk), .rst_n(rst_n), .instr(instr), .flush(flush), .wb(wb),
		.spec_wr(spec_wr), .restore(restore), .saved(saved), .ctrl(ctrl), .imm(imm),
		.reg_1_data(reg_1_data), .reg_2_data(reg_2_data), .spec(spec),
		.pass_cnt(pass_cnt), .fail_cnt(fail_cnt)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Simulation failed");
			$finish;
		end
	end

	function automatic logic [`DATA_W-1:0] make_instr(input logic [4:0] op,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2,
		input logic [11:0] low);
		return {op, rd, rs1, rs2, low};
	endfunction

	function automatic logic [`DATA_W-1:0] reg_pattern(input int r);
		return (r * 32'h0101_0101) ^ 32'hA5C3_0000;
	endfunction

	// inputs change 2 ns after the edge
	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic idle_inputs();
		instr = make_instr(cpu_pkg::OP_NOP, 5'd0, 5'd0, 5'd0, 12'h000);
		flush = 1'b0;
		wb = '0;
		spec_wr = '0;
		restore = 1'b0;
		saved = '0;
	endtask

	task automatic report_test(input string name);
		if (fail_cnt == fail_mark) begin
			$display("test %s: passed", name);
		end else begin
			$display("test %s: %0d check(s) failed", name, fail_cnt - fail_mark);
		end
		fail_mark = fail_cnt;
	endtask

	initial begin
		rst_n = 1'b0;
		idle_inputs();
		repeat (RESET_CYC) @(posedge clk);
		#2;
		rst_n = 1'b1;

		// every legal opcode, sources on LR and FL
		for (int op = 0; op < 32; op++) begin
			if (op < 23 || op == 31) begin
				instr = make_instr(5'(op), 5'd3, `REG_LR, `REG_FL, 12'h8A5);
				next_cycle();
				instr = make_instr(5'(op), 5'd7, `REG_FL, `REG_LR, 12'h3C4);
				next_cycle();
			end
		end
		report_test("1 legal opcodes");

		for (int op = 23; op < 31; op++) begin
			rnd = $random(seed);
			instr = {5'(op), rnd[26:0]};
			next_cycle();
		end
		flush = 1'b1;
		for (int op = 0; op < 32; op++) begin
			rnd = $random(seed);
			instr = {5'(op), rnd[26:0]};
			next_cycle();
		end
		idle_inputs();
		report_test("2 illegal opcodes and flush");

		// write while reading the same register through the bypass
		for (int r = 1; r < 30; r++) begin
			instr = make_instr(cpu_pkg::OP_ADD, 5'd1, 5'(r), 5'(r - 1), 12'h000);
			wb = '{en: 1'b1, sel: 5'(r), data: reg_pattern(r)};
			next_cycle();
		end
		wb = '0;
		for (int r = 1; r < 30; r++) begin
			instr = make_instr(cpu_pkg::OP_SUB, 5'd2, 5'(r), 5'(30 - r), 12'h000);
			next_cycle();
		end
		for (int i = 0; i < 3; i++) begin
			instr = make_instr(cpu_pkg::OP_AND, 5'd4, prot[i], prot[i], 12'h000);
			wb = '{en: 1'b1, sel: prot[i], data: 32'hDEAD_BEEF};
			next_cycle();
		end
		wb = '0;
		for (int i = 0; i < 3; i++) begin
			instr = make_instr(cpu_pkg::OP_OR, 5'd4, prot[i], prot[2 - i], 12'h000);
			next_cycle();
		end
		report_test("3 register file");

		// LR and FL still hold their reset value here
		next_cycle();
		spec_wr = '{lr_write: 1'b1, lr_data: 32'h1234_5678, fl_write: 1'b1, fl_data: 2'b10};
		next_cycle();
		spec_wr = '0;
		repeat (2) next_cycle();
		spec_wr = '{lr_write: 1'b0, lr_data: 32'h0, fl_write: 1'b1, fl_data: 2'b01};
		next_cycle();
		spec_wr = '{lr_write: 1'b1, lr_data: 32'h0BAD_F00D, fl_write: 1'b0, fl_data: 2'b11};
		next_cycle();
		spec_wr = '{lr_write: 1'b1, lr_data: 32'h7777_0000, fl_write: 1'b1, fl_data: 2'b11};
		restore = 1'b1;
		saved = '{lr: 32'hCAFE_0001, fl: 2'b01};
		next_cycle();
		idle_inputs();
		repeat (2) next_cycle();
		report_test("4 special registers");

		for (int n = 0; n < T5_CYC; n++) begin
			rnd = $random(seed);
			instr = $random(seed);
			flush = (rnd[2:0] == 3'd0);
			restore = (rnd[7:4] == 4'd0);
			wb = '{en: rnd[8], sel: rnd[13:9], data: $random(seed)};
			spec_wr = '{lr_write: rnd[14], lr_data: $random(seed), fl_write: rnd[15],
				fl_data: rnd[17:16]};
			saved = '{lr: $random(seed), fl: rnd[19:18]};
			// often read the register being written
			if (rnd[20]) begin
				instr[`RS1_MSB:`RS1_LSB] = wb.sel;
			end
			next_cycle();
		end
		idle_inputs();
		report_test("5 random traffic");

		$display("checks passed: %0d, checks failed: %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+verilog
verilog/cpu_pkg.sv
verilog/instr_decoder.sv
verilog/reg_file_bypass.sv
verilog/special_regs.sv
verilog/decode_stage.sv
tb/decode_checker.sv
tb/tb_decode_stage.sv
